/* rect_display_top.f */
rtl/rect_pkg.sv
rtl/display_timings.sv
rtl/shape_sequencer.sv
rtl/draw_rectangle.sv
rtl/framebuffer.sv
rtl/rect_display_top.sv
testbench/clock_gen.sv
testbench/tb_rect_display.sv

/* rtl/display_timings.sv */
//================================================
// active area first, then front porch, sync, back porch
// all outputs registered and aligned with sx, sy
//================================================
`timescale 1ns/1ps

module display_timings (
    input  logic                             clk_100m,
    input  logic                             rst_n,
    output logic signed [rect_pkg::CORDW-1:0] sx,
    output logic signed [rect_pkg::CORDW-1:0] sy,
    output logic                             de,
    output logic                             hsync,
    output logic                             vsync,
    output logic                             frame,
    output logic                             line
);

    logic signed [rect_pkg::CORDW-1:0] sx_nxt;  // position after this cycle
    logic signed [rect_pkg::CORDW-1:0] sy_nxt;

    always_comb begin
        sx_nxt = sx + 1'b1;
        sy_nxt = sy;
        if (sx == rect_pkg::H_LAST) begin  // end of line
            sx_nxt = '0;
            sy_nxt = (sy == rect_pkg::V_LAST) ? '0 : sy + 1'b1;
        end
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= rect_pkg::H_LAST;  // first clock wraps to 0,0
            sy    <= rect_pkg::V_LAST;
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            de    <= (sx_nxt < rect_pkg::H_ACTIVE) && (sy_nxt < rect_pkg::V_ACTIVE);
            hsync <= (sx_nxt >= rect_pkg::H_ACTIVE + rect_pkg::H_FP) &&
                     (sx_nxt <  rect_pkg::H_ACTIVE + rect_pkg::H_FP + rect_pkg::H_SYNC);
            vsync <= (sy_nxt >= rect_pkg::V_ACTIVE + rect_pkg::V_FP) &&
                     (sy_nxt <  rect_pkg::V_ACTIVE + rect_pkg::V_FP + rect_pkg::V_SYNC);
            frame <= (sx_nxt == 0) && (sy_nxt == 0);  // top left
            line  <= (sx_nxt == 0);                   // every line start
        end
    end

endmodule

/* rtl/draw_rectangle.sv */
//================================================
// expects x0 < x1 and y0 + 1 < y1
// emits 2w+2h-4 pixels, one per cycle with oe high
//================================================
`timescale 1ns/1ps

module draw_rectangle (
    input  logic                              clk_100m,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic                              oe,
    input  logic signed [rect_pkg::CORDW-1:0] x0,
    input  logic signed [rect_pkg::CORDW-1:0] y0,
    input  logic signed [rect_pkg::CORDW-1:0] x1,
    input  logic signed [rect_pkg::CORDW-1:0] y1,
    output logic signed [rect_pkg::CORDW-1:0] x,
    output logic signed [rect_pkg::CORDW-1:0] y,
    output logic                              drawing,
    output logic                              done
);

    enum logic [2:0] {IDLE, TOP, RIGHT, BOTTOM, LEFT} state;

    logic signed [rect_pkg::CORDW-1:0] x0_r;  // corners held for the whole outline
    logic signed [rect_pkg::CORDW-1:0] y0_r;
    logic signed [rect_pkg::CORDW-1:0] x1_r;
    logic signed [rect_pkg::CORDW-1:0] y1_r;

    // current x, y is valid whenever an edge is active and oe is high
    assign drawing = (state != IDLE) && oe;

    always_ff @(posedge clk_100m) begin
        if (state == IDLE && start) begin
            x0_r <= x0;
            y0_r <= y0;
            x1_r <= x1;
            y1_r <= y1;
        end
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
            x     <= '0;
            y     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    x     <= x0;
                    y     <= y0;
                    state <= TOP;
                end
                TOP: if (oe) begin  // left to right, both corners
                    if (x == x1_r) begin
                        y     <= y + 1'b1;
                        state <= RIGHT;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                RIGHT: if (oe) begin  // downwards, bottom corner included
                    if (y == y1_r) begin
                        x     <= x - 1'b1;
                        state <= BOTTOM;
                    end else begin
                        y <= y + 1'b1;
                    end
                end
                BOTTOM: if (oe) begin  // right to left
                    if (x == x0_r) begin
                        y     <= y - 1'b1;
                        state <= LEFT;
                    end else begin
                        x <= x - 1'b1;
                    end
                end
                LEFT: if (oe) begin  // upwards, stops short of top corner
                    if (y == y0_r + 1'b1) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        y <= y - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* rtl/framebuffer.sv */
//================================================
// colour out 2 cycles after sx, sy; syncs delayed to match
// writes outside the framebuffer are dropped
//================================================
`timescale 1ns/1ps

module framebuffer (
    input  logic                                clk_100m,
    input  logic                                rst_n,
    input  logic                                we,
    input  logic signed [rect_pkg::CORDW-1:0]   x,
    input  logic signed [rect_pkg::CORDW-1:0]   y,
    input  logic        [rect_pkg::FB_CIDXW-1:0] cidx,
    input  logic signed [rect_pkg::CORDW-1:0]   sx,
    input  logic signed [rect_pkg::CORDW-1:0]   sy,
    input  logic                                de,
    input  logic                                hsync,
    input  logic                                vsync,
    output logic        [rect_pkg::FB_CHANW-1:0] red,
    output logic        [rect_pkg::FB_CHANW-1:0] green,
    output logic        [rect_pkg::FB_CHANW-1:0] blue,
    output logic                                de_out,
    output logic                                hsync_out,
    output logic                                vsync_out
);

    logic [rect_pkg::FB_CIDXW-1:0] mem [rect_pkg::FB_WIDTH*rect_pkg::FB_HEIGHT];

    logic signed [31:0]                wr_lin;
    logic        [rect_pkg::FB_ADDRW-1:0] wr_addr;
    logic                              wr_in;     // write lands inside
    logic        [rect_pkg::CORDW-1:0] fbx_rd;    // scaled read position
    logic        [rect_pkg::CORDW-1:0] fby_rd;
    logic        [31:0]                rd_lin;
    logic        [rect_pkg::FB_ADDRW-1:0] rd_addr;
    logic        [rect_pkg::FB_CIDXW-1:0] rd_cidx;  // stage 1
    logic        [3*rect_pkg::FB_CHANW-1:0] colour;  // stage 2
    logic                              de_p1, hsync_p1, vsync_p1;

    initial begin
        for (int i = 0; i < rect_pkg::FB_WIDTH * rect_pkg::FB_HEIGHT; i++) begin
            mem[i] = '0;  // background
        end
    end

    // write side
    assign wr_in   = (x >= 0) && (x < rect_pkg::FB_WIDTH) &&
                     (y >= 0) && (y < rect_pkg::FB_HEIGHT);
    assign wr_lin  = y * rect_pkg::FB_WIDTH + x;
    assign wr_addr = wr_lin[rect_pkg::FB_ADDRW-1:0];

    always_ff @(posedge clk_100m) begin
        if (we && wr_in) mem[wr_addr] <= cidx;
    end

    // read side, FB_SCALE is a power of two
    assign fbx_rd  = $unsigned(sx) >> $clog2(rect_pkg::FB_SCALE);
    assign fby_rd  = $unsigned(sy) >> $clog2(rect_pkg::FB_SCALE);
    assign rd_lin  = fby_rd * rect_pkg::FB_WIDTH + fbx_rd;
    assign rd_addr = rd_lin[rect_pkg::FB_ADDRW-1:0];

    always_ff @(posedge clk_100m) begin
        if (de) rd_cidx <= mem[rd_addr];  // blanking reads would fall off the end
        colour <= de_p1 ? rect_pkg::PALETTE[rd_cidx] : '0;
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            {de_p1, hsync_p1, vsync_p1}     <= '0;
            {de_out, hsync_out, vsync_out} <= '0;
        end else begin
            {de_p1, hsync_p1, vsync_p1}     <= {de, hsync, vsync};
            {de_out, hsync_out, vsync_out} <= {de_p1, hsync_p1, vsync_p1};
        end
    end

    assign red   = colour[3*rect_pkg::FB_CHANW-1:2*rect_pkg::FB_CHANW];
    assign green = colour[2*rect_pkg::FB_CHANW-1:rect_pkg::FB_CHANW];
    assign blue  = colour[rect_pkg::FB_CHANW-1:0];

endmodule

/* rtl/rect_display_top.sv */
//================================================
// single clock, one pixel per cycle, no back-pressure
// start is a one-cycle strobe; done pulses after the last shape
//================================================
`timescale 1ns/1ps

module rect_display_top (
    input  logic                               clk_100m,
    input  logic                               rst_n,
    input  logic                               start,
    output logic [rect_pkg::FB_CHANW-1:0]      red,
    output logic [rect_pkg::FB_CHANW-1:0]      green,
    output logic [rect_pkg::FB_CHANW-1:0]      blue,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               de,
    output logic                               busy,
    output logic                               done
);

    logic signed [rect_pkg::CORDW-1:0]   sx, sy;              // scan position
    logic                                tim_de, tim_hsync, tim_vsync;
    logic                                frame;
    logic                                draw_start, draw_oe, draw_done;
    logic signed [rect_pkg::CORDW-1:0]   x0, y0, x1, y1;      // current shape
    logic        [rect_pkg::FB_CIDXW-1:0] cidx;
    logic signed [rect_pkg::CORDW-1:0]   fbx, fby;            // draw pixel
    logic                                drawing;             // doubles as write enable

    display_timings display_timings_inst (
        .clk_100m, .rst_n,
        .sx, .sy,
        .de(tim_de), .hsync(tim_hsync), .vsync(tim_vsync),
        .frame,
        .line()
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m, .rst_n,
        .start, .frame, .draw_done,
        .draw_start, .draw_oe,
        .x0, .y0, .x1, .y1,
        .cidx,
        .busy, .done
    );

    draw_rectangle draw_rectangle_inst (
        .clk_100m, .rst_n,
        .start(draw_start), .oe(draw_oe),
        .x0, .y0, .x1, .y1,
        .x(fbx), .y(fby),
        .drawing,
        .done(draw_done)
    );

    framebuffer framebuffer_inst (
        .clk_100m, .rst_n,
        .we(drawing), .x(fbx), .y(fby), .cidx,
        .sx, .sy,
        .de(tim_de), .hsync(tim_hsync), .vsync(tim_vsync),
        .red, .green, .blue,
        .de_out(de), .hsync_out(hsync), .vsync_out(vsync)
    );

endmodule

/* rtl/rect_pkg.sv */
//================================================
// raster, framebuffer, shape and palette constants
// raster is simulation sized, one pixel per clk_100m
//================================================
package rect_pkg;

    localparam int CORDW = 16;  // signed coordinate width

    // display raster
    localparam int H_ACTIVE = 128;
    localparam int H_FP     = 8;
    localparam int H_SYNC   = 12;
    localparam int H_BP     = 12;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 160
    localparam int V_ACTIVE = 72;
    localparam int V_FP     = 4;
    localparam int V_SYNC   = 6;
    localparam int V_BP     = 8;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 90
    localparam logic signed [CORDW-1:0] H_LAST = CORDW'(H_TOTAL - 1);
    localparam logic signed [CORDW-1:0] V_LAST = CORDW'(V_TOTAL - 1);

    // framebuffer
    localparam int FB_SCALE  = 2;  // power of two only
    localparam int FB_WIDTH  = H_ACTIVE / FB_SCALE;
    localparam int FB_HEIGHT = V_ACTIVE / FB_SCALE;
    localparam int FB_CIDXW  = 4;
    localparam int FB_CHANW  = 4;
    localparam int FB_ADDRW  = 12;

    // 12-bit rgb, entry 0 is the background
    localparam logic [3*FB_CHANW-1:0] PALETTE [2**FB_CIDXW] = '{
        12'h000, 12'h125, 12'h725, 12'h085, 12'hA53, 12'h554, 12'hCCC, 12'hFFE,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3, 12'h3AF, 12'h879, 12'hF7A, 12'hFCA
    };

    // nested rectangles, shape i shrinks by i on every side
    localparam int SHAPE_CNT = 8;
    localparam int SHAPE_IDW = $clog2(SHAPE_CNT);
    localparam logic [SHAPE_IDW-1:0] SHAPE_LAST = SHAPE_IDW'(SHAPE_CNT - 1);
    localparam logic signed [CORDW-1:0] SHAPE_X0 = 16'sd4;
    localparam logic signed [CORDW-1:0] SHAPE_Y0 = 16'sd2;
    localparam logic signed [CORDW-1:0] SHAPE_X1 = 16'sd59;
    localparam logic signed [CORDW-1:0] SHAPE_Y1 = 16'sd33;

    // drawing speed
    localparam int PIX_FRAME = 400;  // pixels per frame at most
    localparam int PIX_CNTW  = $clog2(PIX_FRAME + 1);

endpackage

/* rtl/shape_sequencer.sv */
//================================================
// start is a one-cycle strobe, ignored while busy
// drawing begins at the frame strobe after start
//================================================
`timescale 1ns/1ps

module shape_sequencer (
    input  logic                                clk_100m,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                frame,
    input  logic                                draw_done,
    output logic                                draw_start,
    output logic                                draw_oe,
    output logic signed [rect_pkg::CORDW-1:0]   x0,
    output logic signed [rect_pkg::CORDW-1:0]   y0,
    output logic signed [rect_pkg::CORDW-1:0]   x1,
    output logic signed [rect_pkg::CORDW-1:0]   y1,
    output logic        [rect_pkg::FB_CIDXW-1:0] cidx,
    output logic                                busy,
    output logic                                done
);

    enum logic [2:0] {IDLE, ARMED, INIT, DRAW, FINISH} state;

    logic        [rect_pkg::SHAPE_IDW-1:0] shape_id;
    logic signed [rect_pkg::CORDW-1:0]     shape_off;  // shrink per side
    logic        [rect_pkg::PIX_CNTW-1:0]  cnt_pix;    // pixels this frame

    assign shape_off = {{(rect_pkg::CORDW-rect_pkg::SHAPE_IDW){1'b0}}, shape_id};

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            shape_id   <= '0;
            draw_start <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state <= ARMED;
                    busy  <= 1'b1;
                end
                ARMED: if (frame) begin  // wait for a clean frame edge
                    shape_id <= '0;
                    state    <= INIT;
                end
                INIT: begin  // corners load this cycle
                    draw_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: if (draw_done) begin
                    if (shape_id == rect_pkg::SHAPE_LAST) begin
                        state <= FINISH;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= INIT;
                    end
                end
                FINISH: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == INIT) begin
            x0   <= rect_pkg::SHAPE_X0 + shape_off;
            y0   <= rect_pkg::SHAPE_Y0 + shape_off;
            x1   <= rect_pkg::SHAPE_X1 - shape_off;
            y1   <= rect_pkg::SHAPE_Y1 - shape_off;
            cidx <= {{(rect_pkg::FB_CIDXW-rect_pkg::SHAPE_IDW){1'b0}}, shape_id} + 1'b1;
        end
    end

    // pixel budget, refilled every frame
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            cnt_pix <= '0;
        end else if (frame) begin
            cnt_pix <= '0;
        end else if (state == DRAW && draw_oe) begin
            cnt_pix <= cnt_pix + 1'b1;  // counts every enabled draw cycle
        end
    end

    assign draw_oe = (cnt_pix < rect_pkg::PIX_FRAME);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run tb_rect_display with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f rect_display_top.f \
    --top-module tb_rect_display -o sim_rect_display \
    && ./obj_dir/sim_rect_display > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* testbench/clock_gen.sv */
//================================================
// 100 MHz clock, rst_n low for the first 10 cycles
// reset is released on a falling edge
//================================================
`timescale 1ns/1ps

module clock_gen (
    output logic clk_100m,
    output logic rst_n
);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk_100m);
        @(negedge clk_100m);
        rst_n = 1'b1;
    end

endmodule

/* testbench/tb_rect_display.sv */
//================================================
// directed tests with DUT inputs driven on the falling edge
// whole run bounded at 14 frames of 14,400 cycles
//================================================
`timescale 1ns/1ps

module tb_rect_display;

    localparam int FRAME_CYC      = 14400;           // 160 x 90 raster
    localparam int LINE_CYC       = 160;
    localparam int TIMEOUT_CYCLES = 14 * FRAME_CYC;  // five tests with three drawings
    localparam int N_PIX          = 128 * 72;
    localparam int SEL_HSYNC      = 0;
    localparam int SEL_VSYNC      = 1;
    localparam int SEL_DE         = 2;

    logic        clk_100m;
    logic        rst_n;
    logic        start = 1'b0;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic        busy;
    logic        done;

    logic [11:0] frame_buf [N_PIX];  // last captured frame in row-major order
    int          cycle       = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          vsync_rises = 0;
    int          done_pulses = 0;
    logic        vsync_d     = 1'b0;

    clock_gen clock_gen_inst (.clk_100m, .rst_n);

    rect_display_top rect_display_top_inst (
        .clk_100m, .rst_n, .start,
        .red, .green, .blue,
        .hsync, .vsync, .de,
        .busy, .done
    );

    always @(posedge clk_100m) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    // event counters sampled mid-cycle
    always @(negedge clk_100m) begin
        vsync_d <= vsync;
        if (vsync && !vsync_d) vsync_rises <= vsync_rises + 1;
        if (done) done_pulses <= done_pulses + 1;  // done is one cycle wide
    end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic expect_true(input string what, input bit cond);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    function automatic logic sync_level(input int sel);
        case (sel)
            SEL_HSYNC: return hsync;
            SEL_VSYNC: return vsync;
            default:   return de;
        endcase
    endfunction

    // returns on the first sample where the signal has just reached level
    task automatic wait_edge(input int sel, input logic level);
        do @(negedge clk_100m); while (sync_level(sel) == level);
        do @(negedge clk_100m); while (sync_level(sel) != level);
    endtask

    task automatic pulse_start();
        @(negedge clk_100m);
        start = 1'b1;
        @(negedge clk_100m);
        start = 1'b0;
    endtask

    task automatic wait_done(input int target);
        while (done_pulses < target) @(negedge clk_100m);  // done_pulses lags done by one sample
    endtask

    task automatic capture_frame();
        int n = 0;
        wait_edge(SEL_VSYNC, 1'b0);
        while (n < N_PIX) begin
            @(negedge clk_100m);
            if (de) begin
                frame_buf[n] = {red, green, blue};
                n++;
            end
        end
    endtask

    function automatic int count_lit();
        int lit = 0;
        for (int i = 0; i < N_PIX; i++) begin
            if (frame_buf[i] != 12'h000) lit++;
        end
        return lit;
    endfunction

    // fb pixel (dx/2, dy/2) tested against every shape outline
    function automatic logic [11:0] expected_rgb(input int dx, input int dy);
        int          fx;
        int          fy;
        int          lo_x;
        int          lo_y;
        int          hi_x;
        int          hi_y;
        logic [11:0] rgb;
        fx  = dx / 2;
        fy  = dy / 2;
        rgb = 12'h000;  // background
        for (int i = 0; i < rect_pkg::SHAPE_CNT; i++) begin
            lo_x = rect_pkg::SHAPE_X0 + i;
            lo_y = rect_pkg::SHAPE_Y0 + i;
            hi_x = rect_pkg::SHAPE_X1 - i;
            hi_y = rect_pkg::SHAPE_Y1 - i;
            if (((fy == lo_y || fy == hi_y) && fx >= lo_x && fx <= hi_x) ||
                ((fx == lo_x || fx == hi_x) && fy >= lo_y && fy <= hi_y)) begin
                rgb = rect_pkg::PALETTE[i+1];
            end
        end
        return rgb;
    endfunction

    task automatic compare_frame(input string name, input bit drawn);
        logic [11:0] exp;
        int          shown = 0;
        for (int dy = 0; dy < 72; dy++) begin
            for (int dx = 0; dx < 128; dx++) begin
                exp = drawn ? expected_rgb(dx, dy) : 12'h000;
                checks++;
                assert (frame_buf[dy*128+dx] == exp) else begin
                    errors++;
                    if (shown < 10) begin
                        $display("Fail %s: pixel (%0d,%0d) expected %h actual %h",
                                 name, dx, dy, exp, frame_buf[dy*128+dx]);
                    end
                    shown++;
                end
            end
        end
        if (shown > 10) $display("%s: %0d more pixel mismatches not listed", name, shown - 10);
    endtask

    task automatic reset_is_quiet();
        expect_equal("reset_state busy", 0, busy);
        expect_equal("reset_state done", 0, done);
        capture_frame();
        compare_frame("reset_state", 1'b0);
    endtask

    task automatic rate_limit();
        int total = 0;
        int w;
        int h;
        int v0;
        int d0;
        int v_mid;
        int lit;
        int need;
        for (int i = 0; i < rect_pkg::SHAPE_CNT; i++) begin
            w = (rect_pkg::SHAPE_X1 - i) - (rect_pkg::SHAPE_X0 + i) + 1;
            h = (rect_pkg::SHAPE_Y1 - i) - (rect_pkg::SHAPE_Y0 + i) + 1;
            total += 2 * w + 2 * h - 4;  // corners drawn once
        end
        v0 = vsync_rises;
        d0 = done_pulses;
        pulse_start();
        capture_frame();  // lands while shapes are still going in
        v_mid = vsync_rises - v0;
        lit   = count_lit() / 4;
        expect_true("drawing ended before the mid-drawing capture", done_pulses == d0);
        checks++;
        // each vsync rise counted so far is followed by one frame budget
        assert (lit <= v_mid * rect_pkg::PIX_FRAME) else begin
            errors++;
            $display("Fail rate_limit pixels: expected at most %0d actual %0d",
                     v_mid * rect_pkg::PIX_FRAME, lit);
        end
        wait_done(d0 + 1);
        need = (total + rect_pkg::PIX_FRAME - 1) / rect_pkg::PIX_FRAME - 1;
        checks++;
        assert (vsync_rises - v0 >= need) else begin
            errors++;
            $display("Fail rate_limit frames: expected at least %0d actual %0d",
                     need, vsync_rises - v0);
        end
    endtask

    task automatic raster_timing();
        int v_rise;
        int t_h;
        int t_de;
        wait_edge(SEL_VSYNC, 1'b1);
        v_rise = cycle;
        wait_edge(SEL_VSYNC, 1'b0);
        expect_equal("raster_timing vsync width", 6 * LINE_CYC, cycle - v_rise);
        wait_edge(SEL_HSYNC, 1'b1);
        t_h = cycle;
        wait_edge(SEL_HSYNC, 1'b0);
        expect_equal("raster_timing hsync width", 12, cycle - t_h);
        wait_edge(SEL_HSYNC, 1'b1);
        expect_equal("raster_timing hsync period", LINE_CYC, cycle - t_h);
        wait_edge(SEL_DE, 1'b1);  // first active line of next frame
        t_de = cycle;
        wait_edge(SEL_DE, 1'b1);
        expect_equal("raster_timing de period", LINE_CYC, cycle - t_de);
        wait_edge(SEL_VSYNC, 1'b1);
        expect_equal("raster_timing vsync period", FRAME_CYC, cycle - v_rise);
    endtask

    task automatic start_ignored_while_busy();
        int d0;
        d0 = done_pulses;
        repeat ($urandom_range(1, 64)) @(negedge clk_100m);
        pulse_start();
        repeat (3) @(negedge clk_100m);
        expect_true("busy did not rise after start", busy == 1'b1);
        pulse_start();  // lands in armed or draw
        wait_done(d0 + 1);
        repeat (8) @(negedge clk_100m);
        expect_equal("start_while_busy done pulses", 1, done_pulses - d0);
        expect_equal("start_while_busy busy after done", 0, busy);
    endtask

    task automatic full_drawing();
        int d0;
        d0 = done_pulses;
        repeat ($urandom_range(1, 64)) @(negedge clk_100m);
        pulse_start();  // redraw over the finished picture
        wait_done(d0 + 1);
        expect_equal("full_drawing busy after done", 0, busy);
        capture_frame();
        expect_equal("full_drawing done pulses", 1, done_pulses - d0);
        compare_frame("full_drawing", 1'b1);
    endtask

    initial begin
        void'($urandom(8051));
        wait (rst_n === 1'b1);
        @(negedge clk_100m);
        reset_is_quiet();
        rate_limit();
        raster_timing();
        start_ignored_while_busy();
        full_drawing();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
